// File: common/core_pkg.sv
package core_pkg;

	parameter int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [2:0]      funct3_t;

	typedef enum logic [6:0] {
		op_lui    = 7'b0110111,
		op_auipc  = 7'b0010111,
		op_jal    = 7'b1101111,
		op_jalr   = 7'b1100111,
		op_branch = 7'b1100011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_imm    = 7'b0010011
	} opcode_t;

	////////////////////////////////////////////////////////////
	// funct3 codes

	// Branch conditions
	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	// OP-IMM operations
	localparam funct3_t f3_add  = 3'b000;
	localparam funct3_t f3_sll  = 3'b001;
	localparam funct3_t f3_slt  = 3'b010;
	localparam funct3_t f3_sltu = 3'b011;
	localparam funct3_t f3_xor  = 3'b100;
	localparam funct3_t f3_srl  = 3'b101; // SRAI when bit 30 set
	localparam funct3_t f3_or   = 3'b110;
	localparam funct3_t f3_and  = 3'b111;

	// Load and store sizes
	localparam funct3_t f3_b  = 3'b000;
	localparam funct3_t f3_h  = 3'b001;
	localparam funct3_t f3_w  = 3'b010;
	localparam funct3_t f3_bu = 3'b100;
	localparam funct3_t f3_hu = 3'b101;

	////////////////////////////////////////////////////////////
	// Instruction formats, MSB first

	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		funct3_t    funct3;
		reg_addr_t  rd;
		opcode_t    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_addr_t   rs1;
		funct3_t     funct3;
		reg_addr_t   rd;
		opcode_t     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		funct3_t    funct3;
		logic [4:0] imm_lo;
		opcode_t    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		funct3_t    funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_t    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		reg_addr_t   rd;
		opcode_t     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		reg_addr_t  rd;
		opcode_t    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} inst_u;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback
	} ctrl_state_t;

	////////////////////////////////////////////////////////////
	// Four-phase bus bundles

	typedef struct packed {
		logic    req;
		logic    we;
		funct3_t size;
		word_t   addr;
		word_t   wdata;
	} mem_req_t;

	typedef struct packed {
		logic  ack;
		word_t rdata;
	} mem_rsp_t;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic                clk,
	input  core_pkg::reg_addr_t rs1_addr,
	input  core_pkg::reg_addr_t rs2_addr,
	input  core_pkg::reg_addr_t rd_addr,
	input  logic                rf_we,
	input  core_pkg::word_t     rd_data,
	output core_pkg::word_t     rs1_data,
	output core_pkg::word_t     rs2_data
);

	core_pkg::word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk)
	begin
		if (rf_we && rd_addr != '0)
			regs[rd_addr] <= rd_data;
	end

	// Registered reads
	always_ff @(posedge clk)
	begin
		rs1_data <= (rs1_addr == '0) ? '0 : regs[rs1_addr];
		rs2_data <= (rs2_addr == '0) ? '0 : regs[rs2_addr];
	end

endmodule

// File: logic/imm_decode.sv
`timescale 1ns/10ps

module imm_decode (
	input  core_pkg::inst_u inst,
	output core_pkg::word_t imm
);

	always_comb
	begin
		case (inst.r.opcode)
			core_pkg::op_imm, core_pkg::op_load, core_pkg::op_jalr:
				imm = {{20{inst.i.imm[11]}}, inst.i.imm};
			core_pkg::op_store:
				imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
			core_pkg::op_branch: // Offset in halfwords
				imm = {{20{inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
					inst.b.imm4_1, 1'b0};
			core_pkg::op_lui, core_pkg::op_auipc:
				imm = {inst.u.imm, 12'b0};
			core_pkg::op_jal:
				imm = {{12{inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
					inst.j.imm10_1, 1'b0};
			default:
				imm = '0;
		endcase
	end

endmodule

// File: logic/alu.sv
`timescale 1ns/10ps

module alu (
	input  logic            clk,
	input  core_pkg::inst_u inst,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t rs1_data,
	input  core_pkg::word_t imm,
	output core_pkg::word_t alu_result
);

	core_pkg::word_t op_result;
	logic [4:0]      shamt;

	assign shamt = imm[4:0];

	// OP-IMM group
	always_comb
	begin
		case (inst.r.funct3)
			core_pkg::f3_add:  op_result = rs1_data + imm;
			core_pkg::f3_slt:  op_result = {31'b0, $signed(rs1_data) < $signed(imm)};
			core_pkg::f3_sltu: op_result = {31'b0, rs1_data < imm};
			core_pkg::f3_xor:  op_result = rs1_data ^ imm;
			core_pkg::f3_or:   op_result = rs1_data | imm;
			core_pkg::f3_and:  op_result = rs1_data & imm;
			core_pkg::f3_sll:  op_result = rs1_data << shamt;
			core_pkg::f3_srl:
			begin
				if (inst.r.funct7[5]) // Bit 30 selects SRAI
					op_result = $signed(rs1_data) >>> shamt;
				else
					op_result = rs1_data >> shamt;
			end
			default: op_result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		case (inst.r.opcode)
			core_pkg::op_imm:                 alu_result <= op_result;
			core_pkg::op_lui:                 alu_result <= imm;
			core_pkg::op_auipc:               alu_result <= pc + imm;
			core_pkg::op_jal, core_pkg::op_jalr: alu_result <= pc + 32'd4; // Link
			default:                          alu_result <= '0;
		endcase
	end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/10ps

module branch_unit (
	input  logic            clk,
	input  core_pkg::inst_u inst,
	input  core_pkg::word_t pc,
	input  core_pkg::word_t rs1_data,
	input  core_pkg::word_t rs2_data,
	input  core_pkg::word_t imm,
	output core_pkg::word_t next_pc
);

	logic            taken;
	core_pkg::word_t jalr_sum;

	assign jalr_sum = rs1_data + imm;

	always_comb
	begin
		case (inst.b.funct3)
			core_pkg::f3_beq:  taken = (rs1_data == rs2_data);
			core_pkg::f3_bne:  taken = (rs1_data != rs2_data);
			core_pkg::f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
			core_pkg::f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
			core_pkg::f3_bltu: taken = (rs1_data < rs2_data);
			core_pkg::f3_bgeu: taken = (rs1_data >= rs2_data);
			default:           taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		case (inst.r.opcode)
			core_pkg::op_branch: next_pc <= taken ? pc + imm : pc + 32'd4;
			core_pkg::op_jal:    next_pc <= pc + imm;
			core_pkg::op_jalr:   next_pc <= {jalr_sum[core_pkg::xlen-1:1], 1'b0}; // Clear bit 0
			default:             next_pc <= pc + 32'd4;
		endcase
	end

endmodule

// File: logic/core_ctrl.sv
`timescale 1ns/10ps

module core_ctrl #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
)
(
	input  logic                clk,
	input  logic                rst,
	input  core_pkg::mem_rsp_t  imem_rsp,
	input  core_pkg::word_t     alu_result,
	input  core_pkg::word_t     next_pc,
	input  core_pkg::word_t     load_data,
	input  logic                lsu_done,
	output core_pkg::mem_req_t  imem_req,
	output core_pkg::inst_u     inst,
	output core_pkg::word_t     pc,
	output core_pkg::reg_addr_t rs1_addr,
	output core_pkg::reg_addr_t rs2_addr,
	output core_pkg::reg_addr_t rd_addr,
	output logic                rf_we,
	output core_pkg::word_t     rd_data,
	output logic                lsu_start,
	output logic                retire,
	output core_pkg::word_t     retire_pc
);

	core_pkg::ctrl_state_t state;
	core_pkg::opcode_t     opcode;
	logic                  fetch_req;
	logic                  fetch_got; // Instruction latched, waiting for ack low
	logic                  is_load;
	logic                  is_mem;
	logic                  is_jump;
	logic                  writes_rd;

	////////////////////////////////////////////////////////////
	// Opcode classes

	assign opcode  = inst.r.opcode;
	assign is_load = (opcode == core_pkg::op_load);
	assign is_mem  = is_load || (opcode == core_pkg::op_store);
	assign is_jump = (opcode == core_pkg::op_jal) || (opcode == core_pkg::op_jalr)
		|| (opcode == core_pkg::op_branch);

	// Everything but branches and stores has a destination
	assign writes_rd = (opcode == core_pkg::op_lui) || (opcode == core_pkg::op_auipc)
		|| (opcode == core_pkg::op_jal) || (opcode == core_pkg::op_jalr)
		|| is_load || (opcode == core_pkg::op_imm);

	assign rs1_addr = inst.r.rs1;
	assign rs2_addr = inst.r.rs2;
	assign rd_addr  = inst.r.rd;
	assign rd_data  = is_load ? load_data : alu_result;
	assign rf_we    = (state == core_pkg::st_writeback) && writes_rd;

	assign retire    = (state == core_pkg::st_writeback);
	assign retire_pc = pc; // PC moves only at the end of writeback

	assign imem_req = '{req: fetch_req, we: 1'b0, size: core_pkg::f3_w, addr: pc, wdata: '0};

	////////////////////////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state     <= core_pkg::st_fetch;
			pc        <= RESET_PC;
			fetch_req <= 1'b0;
			fetch_got <= 1'b0;
			lsu_start <= 1'b0;
		end
		else
		begin
			lsu_start <= 1'b0;
			case (state)
				core_pkg::st_fetch:
				begin
					if (fetch_req && imem_rsp.ack)
					begin
						fetch_req <= 1'b0;
						fetch_got <= 1'b1;
					end
					else if (fetch_got && !imem_rsp.ack)
					begin
						fetch_got <= 1'b0;
						state     <= core_pkg::st_decode;
					end
					else if (!fetch_req && !fetch_got && !imem_rsp.ack)
						fetch_req <= 1'b1; // Previous ack has fallen
				end
				core_pkg::st_decode:
					state <= core_pkg::st_execute;
				core_pkg::st_execute:
				begin
					lsu_start <= is_mem;
					state     <= is_mem ? core_pkg::st_memory : core_pkg::st_writeback;
				end
				core_pkg::st_memory:
				begin
					if (lsu_done)
						state <= core_pkg::st_writeback;
				end
				core_pkg::st_writeback:
				begin
					pc    <= is_jump ? next_pc : pc + 32'd4;
					state <= core_pkg::st_fetch;
				end
				default:
					state <= core_pkg::st_fetch;
			endcase
		end
	end

	// Latch on rising ack, held for the rest of the instruction
	always_ff @(posedge clk)
	begin
		if (state == core_pkg::st_fetch && fetch_req && imem_rsp.ack)
			inst <= imem_rsp.rdata;
	end

endmodule

// File: lsu/lsu.sv
`timescale 1ns/10ps

module lsu (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  core_pkg::inst_u    inst,
	input  core_pkg::word_t    rs1_data,
	input  core_pkg::word_t    rs2_data,
	input  core_pkg::word_t    imm,
	input  core_pkg::mem_rsp_t dmem_rsp,
	output core_pkg::mem_req_t dmem_req,
	output core_pkg::word_t    load_data,
	output logic               done
);

	logic              req_q;
	logic              we_q;
	logic              wait_low; // Data taken, waiting for ack low
	core_pkg::funct3_t size_q;
	core_pkg::word_t   addr_q;
	core_pkg::word_t   wdata_q;
	core_pkg::word_t   store_data;
	core_pkg::word_t   load_ext;

	assign dmem_req = '{req: req_q, we: we_q, size: size_q, addr: addr_q, wdata: wdata_q};

	////////////////////////////////////////////////////////////
	// Data sizing, always from the low end of the word

	always_comb
	begin
		case (inst.s.funct3)
			core_pkg::f3_b: store_data = {24'b0, rs2_data[7:0]};
			core_pkg::f3_h: store_data = {16'b0, rs2_data[15:0]};
			default:        store_data = rs2_data;
		endcase
	end

	always_comb
	begin
		case (size_q)
			core_pkg::f3_b:  load_ext = {{24{dmem_rsp.rdata[7]}}, dmem_rsp.rdata[7:0]};
			core_pkg::f3_h:  load_ext = {{16{dmem_rsp.rdata[15]}}, dmem_rsp.rdata[15:0]};
			core_pkg::f3_bu: load_ext = {24'b0, dmem_rsp.rdata[7:0]};
			core_pkg::f3_hu: load_ext = {16'b0, dmem_rsp.rdata[15:0]};
			default:         load_ext = dmem_rsp.rdata;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Four-phase handshake

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			req_q    <= 1'b0;
			wait_low <= 1'b0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
				req_q <= 1'b1;
			else if (req_q && dmem_rsp.ack)
			begin
				req_q    <= 1'b0;
				wait_low <= 1'b1;
			end
			else if (wait_low && !dmem_rsp.ack)
			begin
				wait_low <= 1'b0;
				done     <= 1'b1; // Handshake closed
			end
		end
	end

	// Request fields held stable while req is high
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			we_q    <= (inst.s.opcode == core_pkg::op_store);
			size_q  <= inst.s.funct3;
			addr_q  <= rs1_data + imm;
			wdata_q <= store_data;
		end
		if (req_q && dmem_rsp.ack && !we_q)
			load_data <= load_ext;
	end

endmodule

// File: logic/core_top.sv
`timescale 1ns/10ps

module core_top #(
	parameter core_pkg::word_t RESET_PC = 32'h0000_0000
)
(
	input  logic               clk,
	input  logic               rst,
	output core_pkg::mem_req_t imem_req,
	input  core_pkg::mem_rsp_t imem_rsp,
	output core_pkg::mem_req_t dmem_req,
	input  core_pkg::mem_rsp_t dmem_rsp,
	output logic               retire,
	output core_pkg::word_t    retire_pc
);

	core_pkg::inst_u     inst;
	core_pkg::word_t     pc;
	core_pkg::reg_addr_t rs1_addr;
	core_pkg::reg_addr_t rs2_addr;
	core_pkg::reg_addr_t rd_addr;
	logic                rf_we;
	core_pkg::word_t     rd_data;
	core_pkg::word_t     rs1_data;
	core_pkg::word_t     rs2_data;
	core_pkg::word_t     imm;
	core_pkg::word_t     alu_result;
	core_pkg::word_t     next_pc;
	core_pkg::word_t     load_data;
	logic                lsu_start;
	logic                lsu_done;

	core_ctrl #(
		.RESET_PC(RESET_PC)
	) ctrl0 (
		.clk(clk),
		.rst(rst),
		.imem_rsp(imem_rsp),
		.alu_result(alu_result),
		.next_pc(next_pc),
		.load_data(load_data),
		.lsu_done(lsu_done),
		.imem_req(imem_req),
		.inst(inst),
		.pc(pc),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rd_addr(rd_addr),
		.rf_we(rf_we),
		.rd_data(rd_data),
		.lsu_start(lsu_start),
		.retire(retire),
		.retire_pc(retire_pc)
	);

	reg_file rf0 (
		.clk(clk),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rd_addr(rd_addr),
		.rf_we(rf_we),
		.rd_data(rd_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	imm_decode imm0 (
		.inst(inst),
		.imm(imm)
	);

	alu alu0 (
		.clk(clk),
		.inst(inst),
		.pc(pc),
		.rs1_data(rs1_data),
		.imm(imm),
		.alu_result(alu_result)
	);

	branch_unit br0 (
		.clk(clk),
		.inst(inst),
		.pc(pc),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.next_pc(next_pc)
	);

	lsu lsu0 (
		.clk(clk),
		.rst(rst),
		.start(lsu_start),
		.inst(inst),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.imm(imm),
		.dmem_rsp(dmem_rsp),
		.dmem_req(dmem_req),
		.load_data(load_data),
		.done(lsu_done)
	);

endmodule

// File: test/core_tb.sv
`timescale 1ns/10ps

module core_tb;

	localparam int period_ns   = 100;
	localparam int drive_delay = 1;   // Inputs change this long after the rising edge
	localparam int test_cycles = 200; // Upper bound for one test, in clock cycles
	localparam logic [31:0] load_word = 32'hF1E2_8384;
	localparam logic [11:0] mark_bad  = 12'h0BA;

	logic                clk;
	logic                rst;
	core_pkg::mem_req_t  imem_req;
	core_pkg::mem_rsp_t  imem_rsp;
	core_pkg::mem_req_t  dmem_req;
	core_pkg::mem_rsp_t  dmem_rsp;
	logic                retire;
	core_pkg::word_t     retire_pc;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] st_addr [0:63]; // Stores seen on the data bus
	logic [31:0] st_data [0:63];
	logic [2:0]  st_size [0:63];
	logic [31:0] ret_pc [0:1023];
	int          store_cnt;
	int          ret_cnt;
	logic [31:0] i_rng = 32'd22189;
	logic [31:0] d_rng = 32'd22189;
	int          i_wait;
	int          d_wait;
	bit          i_busy;
	bit          d_busy;

	// Test table
	string       t_name [0:63];
	int          t_first [0:63];
	int          t_last [0:63];
	int          t_nret [0:63];
	logic [31:0] t_addr [0:63];
	logic [31:0] t_data [0:63];
	logic [2:0]  t_size [0:63];
	int          n_tests;
	int          pc_idx;
	bit          table_done;
	int          pass_cnt;
	int          fail_cnt;

	core_top #(
		.RESET_PC(32'h0000_0000)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.imem_req(imem_req),
		.imem_rsp(imem_rsp),
		.dmem_req(dmem_req),
		.dmem_rsp(dmem_rsp),
		.retire(retire),
		.retire_pc(retire_pc)
	);

	////////////////////////////////////////////////////////////
	// Instruction encoders and helpers

	function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
		input logic [2:0] f3, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[pc_idx] = w;
		pc_idx++;
	endtask

	task automatic open_test(input string name);
		t_name[n_tests]  = name;
		t_first[n_tests] = pc_idx;
	endtask

	// Emits the checking store and closes the table row
	task automatic check_store(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [31:0] exp, input int skipped);
		logic [31:0] a;
		a = 32'h200 + n_tests * 4;
		emit(enc_s(f3, 5'd0, rs2, a[11:0]));
		t_last[n_tests] = pc_idx - 1;
		t_nret[n_tests] = pc_idx - t_first[n_tests] - skipped;
		t_addr[n_tests] = a;
		t_data[n_tests] = exp;
		t_size[n_tests] = f3;
		n_tests++;
	endtask

	// Marker register x15 ends up good only on the right path
	task automatic branch_test(input string name, input logic [2:0] f3,
		input logic [4:0] rs1, input logic [4:0] rs2, input bit taken);
		logic [11:0] good;
		good = 12'h100 + n_tests;
		open_test(name);
		emit(enc_i(core_pkg::op_imm, 15, core_pkg::f3_add, 0, taken ? good : mark_bad));
		emit(enc_b(f3, rs1, rs2, 13'd8));
		emit(enc_i(core_pkg::op_imm, 15, core_pkg::f3_add, 0, taken ? mark_bad : good));
		check_store(core_pkg::f3_w, 15, {20'b0, good}, taken ? 1 : 0);
	endtask

	task automatic build_program();
		logic [31:0] v;
		int          j;
		open_test("lui_addi");
		emit(enc_u(core_pkg::op_lui, 1, 20'h12345));
		emit(enc_i(core_pkg::op_imm, 2, core_pkg::f3_add, 1, 12'h678));
		check_store(core_pkg::f3_w, 2, 32'h1234_5000 + sext12(12'h678), 0);
		open_test("xori");
		emit(enc_i(core_pkg::op_imm, 3, core_pkg::f3_xor, 2, 12'hFFF));
		check_store(core_pkg::f3_w, 3, 32'h1234_5678 ^ sext12(12'hFFF), 0);
		open_test("ori");
		emit(enc_i(core_pkg::op_imm, 4, core_pkg::f3_or, 2, 12'h0F0));
		check_store(core_pkg::f3_w, 4, 32'h1234_5678 | sext12(12'h0F0), 0);
		open_test("andi");
		emit(enc_i(core_pkg::op_imm, 5, core_pkg::f3_and, 2, 12'h7F0));
		check_store(core_pkg::f3_w, 5, 32'h1234_5678 & sext12(12'h7F0), 0);
		open_test("slti");
		emit(enc_u(core_pkg::op_lui, 6, 20'h80000));
		emit(enc_i(core_pkg::op_imm, 7, core_pkg::f3_slt, 6, 12'h001));
		check_store(core_pkg::f3_w, 7, ($signed(32'h8000_0000) < $signed(sext12(12'h001))), 0);
		open_test("sltiu");
		emit(enc_i(core_pkg::op_imm, 8, core_pkg::f3_sltu, 2, 12'h800));
		check_store(core_pkg::f3_w, 8, (32'h1234_5678 < sext12(12'h800)), 0);

		// Shifts of a negative value
		v = 32'hF0F0_F000 + sext12(12'h0F0);
		open_test("slli");
		emit(enc_u(core_pkg::op_lui, 9, 20'hF0F0F));
		emit(enc_i(core_pkg::op_imm, 9, core_pkg::f3_add, 9, 12'h0F0));
		emit(enc_i(core_pkg::op_imm, 10, core_pkg::f3_sll, 9, 12'h004));
		check_store(core_pkg::f3_w, 10, v << 4, 0);
		open_test("srli");
		emit(enc_i(core_pkg::op_imm, 11, core_pkg::f3_srl, 9, 12'h008));
		check_store(core_pkg::f3_w, 11, v >> 8, 0);
		open_test("srai");
		emit(enc_i(core_pkg::op_imm, 12, core_pkg::f3_srl, 9, 12'h408));
		check_store(core_pkg::f3_w, 12, {{8{v[31]}}, v[31:8]}, 0);

		// x13 = -1, x14 = 1 for the branch conditions
		open_test("branch_setup");
		emit(enc_i(core_pkg::op_imm, 13, core_pkg::f3_add, 0, 12'hFFF));
		emit(enc_i(core_pkg::op_imm, 14, core_pkg::f3_add, 0, 12'h001));
		check_store(core_pkg::f3_w, 13, 32'hFFFF_FFFF, 0);
		branch_test("beq_taken", core_pkg::f3_beq, 14, 14, 1);
		branch_test("beq_not", core_pkg::f3_beq, 13, 14, 0);
		branch_test("bne_taken", core_pkg::f3_bne, 13, 14, 1);
		branch_test("bne_not", core_pkg::f3_bne, 14, 14, 0);
		branch_test("blt_taken", core_pkg::f3_blt, 13, 14, 1);
		branch_test("blt_not", core_pkg::f3_blt, 14, 13, 0);
		branch_test("bge_taken", core_pkg::f3_bge, 14, 13, 1);
		branch_test("bge_not", core_pkg::f3_bge, 13, 14, 0);
		branch_test("bltu_taken", core_pkg::f3_bltu, 14, 13, 1);
		branch_test("bltu_not", core_pkg::f3_bltu, 13, 14, 0);
		branch_test("bgeu_taken", core_pkg::f3_bgeu, 13, 14, 1);
		branch_test("bgeu_not", core_pkg::f3_bgeu, 14, 13, 0);

		// Jumps store their link value
		open_test("jal");
		j = pc_idx;
		emit(enc_j(16, 21'd8));
		emit(enc_i(core_pkg::op_imm, 16, core_pkg::f3_add, 0, mark_bad));
		check_store(core_pkg::f3_w, 16, (j + 1) * 4, 1);
		open_test("jalr_odd");
		j = pc_idx;
		v = (j + 3) * 4;
		emit(enc_i(core_pkg::op_imm, 18, core_pkg::f3_add, 0, v[11:0]));
		emit(enc_i(core_pkg::op_jalr, 19, 3'b000, 18, 12'h001)); // Odd sum
		emit(enc_i(core_pkg::op_imm, 19, core_pkg::f3_add, 0, mark_bad));
		check_store(core_pkg::f3_w, 19, (j + 2) * 4, 1);

		// Loads from the preset word at 0x100, base 0xF0 plus 0x10
		open_test("lb");
		emit(enc_i(core_pkg::op_imm, 20, core_pkg::f3_add, 0, 12'h0F0));
		emit(enc_i(core_pkg::op_load, 21, core_pkg::f3_b, 20, 12'h010));
		check_store(core_pkg::f3_w, 21, {{24{load_word[7]}}, load_word[7:0]}, 0);
		open_test("lh");
		emit(enc_i(core_pkg::op_load, 21, core_pkg::f3_h, 20, 12'h010));
		check_store(core_pkg::f3_w, 21, {{16{load_word[15]}}, load_word[15:0]}, 0);
		open_test("lbu");
		emit(enc_i(core_pkg::op_load, 21, core_pkg::f3_bu, 20, 12'h010));
		check_store(core_pkg::f3_w, 21, {24'b0, load_word[7:0]}, 0);
		open_test("lhu");
		emit(enc_i(core_pkg::op_load, 21, core_pkg::f3_hu, 20, 12'h010));
		check_store(core_pkg::f3_w, 21, {16'b0, load_word[15:0]}, 0);
		open_test("lw");
		emit(enc_i(core_pkg::op_load, 21, core_pkg::f3_w, 20, 12'h010));
		check_store(core_pkg::f3_w, 21, load_word, 0);
		open_test("sb");
		check_store(core_pkg::f3_b, 21, {24'b0, load_word[7:0]}, 0);
		open_test("sh");
		check_store(core_pkg::f3_h, 21, {16'b0, load_word[15:0]}, 0);
		open_test("auipc");
		j = pc_idx;
		emit(enc_u(core_pkg::op_auipc, 23, 20'h00001));
		check_store(core_pkg::f3_w, 23, 32'h0000_1000 + j * 4, 0);

		open_test("x0_write");
		emit(enc_i(core_pkg::op_imm, 0, core_pkg::f3_add, 14, 12'h055));
		emit(enc_u(core_pkg::op_lui, 0, 20'hABCDE));
		check_store(core_pkg::f3_w, 0, 32'h0, 0);

		emit(enc_j(0, 21'd0)); // Park in a self loop
	endtask

	////////////////////////////////////////////////////////////
	// Clock, bus models and retire monitor

	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// Instruction memory, read only
	always @(posedge clk)
	begin
		#(drive_delay);
		if (rst)
		begin
			imem_rsp.ack = 1'b0;
			i_busy = 1'b0;
		end
		else if (imem_rsp.ack)
		begin
			if (!imem_req.req)
				imem_rsp.ack = 1'b0;
		end
		else if (imem_req.req)
		begin
			if (!i_busy)
			begin
				i_rng = xorshift32(i_rng);
				i_wait = i_rng[1:0]; // 0 to 3 wait cycles
				i_busy = 1'b1;
			end
			if (i_wait == 0)
			begin
				imem_rsp.rdata = imem[imem_req.addr[9:2]];
				imem_rsp.ack = 1'b1;
				i_busy = 1'b0;
			end
			else
				i_wait--;
		end
	end

	// Data memory, stores are logged and not written back
	always @(posedge clk)
	begin
		#(drive_delay);
		if (rst)
		begin
			dmem_rsp.ack = 1'b0;
			d_busy = 1'b0;
		end
		else if (dmem_rsp.ack)
		begin
			if (!dmem_req.req)
				dmem_rsp.ack = 1'b0;
		end
		else if (dmem_req.req)
		begin
			if (!d_busy)
			begin
				d_rng = xorshift32(d_rng);
				d_wait = d_rng[1:0];
				d_busy = 1'b1;
			end
			if (d_wait == 0)
			begin
				if (dmem_req.we && store_cnt < 64)
				begin
					st_addr[store_cnt] = dmem_req.addr;
					st_data[store_cnt] = dmem_req.wdata;
					st_size[store_cnt] = dmem_req.size;
					store_cnt++;
				end
				else
					dmem_rsp.rdata = dmem[dmem_req.addr[9:2]];
				dmem_rsp.ack = 1'b1;
				d_busy = 1'b0;
			end
			else
				d_wait--;
		end
	end

	// retire is high for the whole writeback cycle
	always @(negedge clk)
	begin
		if (!rst && retire && ret_cnt < 1024)
		begin
			ret_pc[ret_cnt] = retire_pc;
			ret_cnt++;
		end
	end

	initial
	begin
		wait (table_done);
		#(n_tests * test_cycles * period_ns);
		$display("Timeout: the tests did not finish within %0d cycles", n_tests * test_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Test sequence

	initial
	begin
		int t;
		int seen;
		int seg;
		int errs;
		rst = 1'b1;
		imem_rsp = '0;
		dmem_rsp = '0;
		store_cnt = 0;
		ret_cnt = 0;
		n_tests = 0;
		pc_idx = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		for (int i = 0; i < 256; i++)
		begin
			imem[i] = enc_i(core_pkg::op_imm, 0, core_pkg::f3_add, 0, {4'h0, i[7:0]});
			dmem[i] = {i[7:0], ~i[7:0], 8'h5A ^ i[7:0], i[7:0] + 8'h11};
		end
		dmem[8'h40] = load_word; // Address 0x100
		build_program();
		table_done = 1'b1;
		repeat (2) @(posedge clk);
		#(drive_delay) rst = 1'b0;

		seg = 0;
		for (t = 0; t < n_tests; t++)
		begin
			while (store_cnt <= t)
				@(posedge clk);
			seen = ret_cnt;
			while (ret_cnt <= seen) // Wait for the store to retire
				@(posedge clk);
			errs = 0;
			if (st_addr[t] !== t_addr[t])
			begin
				$display("** Error: %s store address expected %h, actual %h",
					t_name[t], t_addr[t], st_addr[t]);
				errs++;
			end
			if (st_data[t] !== t_data[t])
			begin
				$display("** Error: %s store data expected %h, actual %h",
					t_name[t], t_data[t], st_data[t]);
				errs++;
			end
			if (st_size[t] !== t_size[t])
			begin
				$display("** Error: %s store size expected %h, actual %h",
					t_name[t], t_size[t], st_size[t]);
				errs++;
			end
			if (ret_cnt - seg != t_nret[t])
			begin
				$display("** Error: %s retired instructions expected %0d, actual %0d",
					t_name[t], t_nret[t], ret_cnt - seg);
				errs++;
			end
			if (ret_pc[seg] !== t_first[t] * 4)
			begin
				$display("** Error: %s first retire PC expected %h, actual %h",
					t_name[t], t_first[t] * 4, ret_pc[seg]);
				errs++;
			end
			if (ret_pc[ret_cnt - 1] !== t_last[t] * 4)
			begin
				$display("** Error: %s last retire PC expected %h, actual %h",
					t_name[t], t_last[t] * 4, ret_pc[ret_cnt - 1]);
				errs++;
			end
			seg = ret_cnt;
			if (errs == 0)
			begin
				pass_cnt++;
				$display("PASS %s", t_name[t]);
			end
			else
			begin
				fail_cnt++;
				$display("FAIL %s", t_name[t]);
			end
		end

		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: flist.f
common/core_pkg.sv
logic/reg_file.sv
logic/imm_decode.sv
logic/alu.sv
logic/branch_unit.sv
logic/core_ctrl.sv
lsu/lsu.sv
logic/core_top.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: core

sources:
  - common/core_pkg.sv
  - logic/reg_file.sv
  - logic/imm_decode.sv
  - logic/alu.sv
  - logic/branch_unit.sv
  - logic/core_ctrl.sv
  - lsu/lsu.sv
  - logic/core_top.sv
  - target: test
    files:
      - test/core_tb.sv
